// ==== Bender.yml ====
package:
  name: ooo_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/ooo_pkg.sv
      - verilog/dispatch_unit.sv
      - verilog/exec_lane.sv
      - verilog/rob.sv
      - verilog/arch_regfile.sv
      - verilog/ooo_core_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - test/tb_ooo_core.sv

// ==== include/ooo_params.svh ====
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// datapath width
`define OOO_XLEN 32

// architectural registers
`define OOO_NREGS 16
`define OOO_REG_W 4

// reorder buffer, pointers carry one extra wrap bit
`define OOO_ROB_DEPTH 8
`define OOO_ROB_ADDR_W 3

// execution resources
`define OOO_NUM_LANES 2
`define OOO_RETIRE_WIDTH 2
`define OOO_MUL_LATENCY 3

`endif

// ==== project.f ====
+incdir+include
verilog/ooo_pkg.sv
verilog/dispatch_unit.sv
verilog/exec_lane.sv
verilog/rob.sv
verilog/arch_regfile.sv
verilog/ooo_core_top.sv
test/tb_ooo_core.sv

// ==== test/tb_ooo_core.sv ====
`timescale 1ns/10ps
`include "ooo_params.svh"

module tb_ooo_core
    import ooo_pkg::*;
();

    localparam int TIMEOUT = 200;
    localparam int RW      = `OOO_RETIRE_WIDTH;

    logic                   clk;
    logic                   rst_n;
    logic                   flush;
    logic                   in_valid;
    instr_t                 in_instr;
    logic                   in_ready;
    retire_t [RW-1:0]       retire;

    // reference model state, updated in program order at acceptance
    logic [`OOO_XLEN-1:0]   model_regs [`OOO_NREGS];
    // values the register file has actually taken from retire
    logic [`OOO_XLEN-1:0]   committed [`OOO_NREGS];
    retire_t                exp_q [$];
    // rob tag the next accepted instruction gets
    rob_tag_t               next_tag;

    string                  cur_test;
    int                     test_errors;
    int                     total_errors;
    int                     tests_passed;
    int                     tests_failed;
    logic                   stall_seen;
    integer                 seed;

    ooo_core_top ooo_core_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .in_ready (in_ready),
        .retire   (retire)
    );

    always #2 clk = ~clk;

    task automatic note_error();
        test_errors++;
        total_errors++;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [`OOO_XLEN-1:0] expected_value(input alu_op_e op,
            input logic [`OOO_XLEN-1:0] a, input logic [`OOO_XLEN-1:0] b);
        logic [2*`OOO_XLEN-1:0] prod;
        prod = a * b;
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            OP_MUL:  return prod[`OOO_XLEN-1:0];
            default: return '0;
        endcase
    endfunction

    function automatic instr_t make_instr(input alu_op_e op, input logic [3:0] dst,
            input logic [3:0] src1, input logic [3:0] src2, input logic [15:0] imm,
            input logic use_imm);
        instr_t ins;
        ins.op      = op;
        ins.dst     = dst;
        ins.src1    = src1;
        ins.src2    = src2;
        ins.imm     = imm;
        ins.use_imm = use_imm;
        return ins;
    endfunction

    task automatic model_accept(input instr_t ins);
        logic [`OOO_XLEN-1:0] a;
        logic [`OOO_XLEN-1:0] b;
        retire_t              exp;
        a = model_regs[ins.src1];
        b = ins.use_imm ? {{(`OOO_XLEN-16){1'b0}}, ins.imm} : model_regs[ins.src2];
        exp       = '0;
        exp.valid = 1'b1;
        exp.dst   = ins.dst;
        exp.value = expected_value(ins.op, a, b);
        exp.tag   = next_tag;
        next_tag  = next_tag + 1'b1;
        // r0 keeps reading zero
        if (ins.dst != '0) begin
            model_regs[ins.dst] = exp.value;
        end
        exp_q.push_back(exp);
    endtask

    // hold in_valid until the core takes the instruction
    task automatic send_instr(input instr_t ins);
        int   waited;
        logic accepted;
        in_valid = 1'b1;
        in_instr = ins;
        waited   = 0;
        @(negedge clk);
        if (!in_ready) begin
            stall_seen = 1'b1;
        end
        while (!in_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        accepted = in_ready;
        next_cycle();
        in_valid = 1'b0;
        if (accepted) begin
            model_accept(ins);
        end else begin
            $display("%s: timed out waiting for in_ready", cur_test);
            note_error();
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d instructions never retired", cur_test, exp_q.size());
            note_error();
        end
    endtask

    task automatic check_idle(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            if (in_ready !== 1'b1) begin
                $display("error %s: in_ready expected 1 actual %b", cur_test, in_ready);
                note_error();
            end
            for (int s = 0; s < RW; s++) begin
                if (retire[s].valid !== 1'b0) begin
                    $display("%s: retire slot %0d valid while idle", cur_test, s);
                    note_error();
                end
            end
        end
        next_cycle();
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("%s: ok", cur_test);
            tests_passed++;
        end else begin
            $display("%s: failed with %0d errors", cur_test, test_errors);
            tests_failed++;
        end
    endtask

    // compare every valid retire slot against the model, oldest first
    always @(negedge clk) begin
        retire_t got;
        retire_t want;
        if (rst_n) begin
            for (int s = 0; s < RW; s++) begin
                got = retire[s];
                if (got.valid) begin
                    if (s > 0 && !retire[s-1].valid) begin
                        $display("%s: retire slot %0d valid above an empty slot", cur_test, s);
                        note_error();
                    end
                    if (exp_q.size() == 0) begin
                        $display("%s: retire to r%0d with nothing outstanding", cur_test, got.dst);
                        note_error();
                    end else begin
                        want = exp_q.pop_front();
                        if (got.dst !== want.dst) begin
                            $display("error %s: retire dst expected %0d actual %0d",
                                     cur_test, want.dst, got.dst);
                            note_error();
                        end
                        if (got.value !== want.value) begin
                            $display("error %s: retire value expected %h actual %h",
                                     cur_test, want.value, got.value);
                            note_error();
                        end
                        if (got.tag !== want.tag) begin
                            $display("error %s: retire tag expected %0d actual %0d",
                                     cur_test, want.tag, got.tag);
                            note_error();
                        end
                        if (want.dst != '0) begin
                            committed[want.dst] = want.value;
                        end
                    end
                end
            end
        end
    end

    task automatic reset_stays_idle();
        start_test("reset_idle");
        check_idle(10);
        end_test();
    endtask

    task automatic opcodes_retire();
        alu_op_e ops [5];
        ops = '{OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_MUL};
        start_test("each_opcode");
        send_instr(make_instr(OP_ADD, 4'd1, 4'd0, 4'd0, 16'h1234, 1'b1));
        send_instr(make_instr(OP_XOR, 4'd2, 4'd0, 4'd0, 16'hbeef, 1'b1));
        foreach (ops[i]) begin
            send_instr(make_instr(ops[i], 4'd3, 4'd1, 4'd0, 16'h0f0f, 1'b1));
            send_instr(make_instr(ops[i], 4'd4, 4'd1, 4'd2, 16'h0000, 1'b0));
        end
        // write to r0 is dropped, then r0 is read back
        send_instr(make_instr(OP_ADD, 4'd0, 4'd1, 4'd0, 16'h0055, 1'b1));
        send_instr(make_instr(OP_ADD, 4'd5, 4'd0, 4'd0, 16'h0001, 1'b1));
        send_instr(make_instr(OP_XOR, 4'd6, 4'd0, 4'd0, 16'h0000, 1'b0));
        drain();
        end_test();
    endtask

    task automatic dep_chain_forwards();
        start_test("dep_chain");
        send_instr(make_instr(OP_ADD, 4'd6, 4'd0, 4'd0, 16'h0003, 1'b1));
        send_instr(make_instr(OP_ADD, 4'd6, 4'd6, 4'd0, 16'h0005, 1'b1));
        send_instr(make_instr(OP_MUL, 4'd7, 4'd6, 4'd6, 16'h0000, 1'b0));
        send_instr(make_instr(OP_MUL, 4'd7, 4'd7, 4'd1, 16'h0000, 1'b0));
        send_instr(make_instr(OP_XOR, 4'd8, 4'd7, 4'd0, 16'habcd, 1'b1));
        send_instr(make_instr(OP_SUB, 4'd9, 4'd8, 4'd6, 16'h0000, 1'b0));
        send_instr(make_instr(OP_AND, 4'd10, 4'd9, 4'd7, 16'h0000, 1'b0));
        drain();
        // producers have retired, sources come from the register file
        send_instr(make_instr(OP_ADD, 4'd11, 4'd10, 4'd9, 16'h0000, 1'b0));
        send_instr(make_instr(OP_SUB, 4'd12, 4'd11, 4'd8, 16'h0000, 1'b0));
        drain();
        end_test();
    endtask

    task automatic mul_retires_in_order();
        start_test("mul_order");
        // the adds finish first, the monitor expects the multiply first
        send_instr(make_instr(OP_MUL, 4'd12, 4'd7, 4'd8, 16'h0000, 1'b0));
        send_instr(make_instr(OP_ADD, 4'd13, 4'd0, 4'd0, 16'h0001, 1'b1));
        send_instr(make_instr(OP_ADD, 4'd14, 4'd1, 4'd0, 16'h0002, 1'b1));
        send_instr(make_instr(OP_XOR, 4'd15, 4'd2, 4'd0, 16'h0003, 1'b1));
        drain();
        end_test();
    endtask

    task automatic random_stream_retires();
        logic [31:0] rnd;
        logic [31:0] rnd_imm;
        logic [2:0]  opsel;
        start_test("random_stream");
        stall_seen = 1'b0;
        // low registers only, so dependencies are frequent
        for (int n = 0; n < 60; n++) begin
            rnd     = $random(seed);
            rnd_imm = $random(seed);
            opsel   = 3'(rnd[7:0] % 8'd5);
            send_instr(make_instr(alu_op_e'(opsel), {1'b0, rnd[10:8]}, {1'b0, rnd[13:11]},
                                  {1'b0, rnd[16:14]}, rnd_imm[15:0], rnd[20]));
        end
        drain();
        if (!stall_seen) begin
            $display("%s: in_ready never went low during the stream", cur_test);
            note_error();
        end
        end_test();
    endtask

    task automatic flush_squashes();
        start_test("flush");
        send_instr(make_instr(OP_MUL, 4'd1, 4'd7, 4'd8, 16'h0000, 1'b0));
        send_instr(make_instr(OP_MUL, 4'd3, 4'd1, 4'd0, 16'h0013, 1'b1));
        send_instr(make_instr(OP_ADD, 4'd4, 4'd3, 4'd0, 16'h0001, 1'b1));
        send_instr(make_instr(OP_MUL, 4'd5, 4'd9, 4'd10, 16'h0000, 1'b0));
        if (exp_q.size() == 0) begin
            $display("%s: nothing in flight when flush was raised", cur_test);
            note_error();
        end
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        // squashed work is gone, the model follows what really retired
        exp_q.delete();
        model_regs = committed;
        // the emptied rob allocates from entry 0 again
        next_tag = '0;
        check_idle(10);
        send_instr(make_instr(OP_ADD, 4'd1, 4'd0, 4'd0, 16'h0011, 1'b1));
        send_instr(make_instr(OP_XOR, 4'd2, 4'd0, 4'd0, 16'h0022, 1'b1));
        send_instr(make_instr(OP_MUL, 4'd3, 4'd0, 4'd0, 16'h0007, 1'b1));
        send_instr(make_instr(OP_SUB, 4'd4, 4'd0, 4'd0, 16'h0005, 1'b1));
        drain();
        end_test();
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        flush        = 1'b0;
        in_valid     = 1'b0;
        in_instr     = '0;
        seed         = 32'h343e_0ef7;
        next_tag     = '0;
        test_errors  = 0;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        stall_seen   = 1'b0;
        cur_test     = "reset";
        for (int r = 0; r < `OOO_NREGS; r++) begin
            model_regs[r] = '0;
            committed[r]  = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        reset_stays_idle();
        opcodes_retire();
        dep_chain_forwards();
        mul_retires_in_order();
        random_stream_retires();
        flush_squashes();

        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog/arch_regfile.sv ====
`timescale 1ns/10ps
`include "ooo_params.svh"

module arch_regfile
    import ooo_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  retire_t [`OOO_RETIRE_WIDTH-1:0]     retire,
    input  logic [`OOO_REG_W-1:0]               rd_addr1,
    input  logic [`OOO_REG_W-1:0]               rd_addr2,
    output logic [`OOO_XLEN-1:0]                rd_data1,
    output logic [`OOO_XLEN-1:0]                rd_data2
);

    logic [`OOO_XLEN-1:0] regs_q [`OOO_NREGS];

    // slot order, so the younger slot lands last on a shared register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < `OOO_NREGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            for (int s = 0; s < `OOO_RETIRE_WIDTH; s++) begin
                if (retire[s].valid && retire[s].dst != '0) begin
                    regs_q[retire[s].dst] <= retire[s].value;
                end
            end
        end
    end

    // r0 is hardwired to zero
    assign rd_data1 = (rd_addr1 == '0) ? '0 : regs_q[rd_addr1];
    assign rd_data2 = (rd_addr2 == '0) ? '0 : regs_q[rd_addr2];

endmodule

// ==== verilog/dispatch_unit.sv ====
`timescale 1ns/10ps
`include "ooo_params.svh"

module dispatch_unit
    import ooo_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                flush,
    input  logic                                in_valid,
    input  instr_t                              in_instr,
    output logic                                in_ready,
    input  logic                                full,
    input  rob_tag_t                            alloc_tag,
    output logic                                alloc_valid,
    output logic [`OOO_REG_W-1:0]               alloc_dst,
    output rob_tag_t                            lookup_tag1,
    output rob_tag_t                            lookup_tag2,
    input  operand_t                            lookup1,
    input  operand_t                            lookup2,
    input  logic [`OOO_NUM_LANES-1:0]           lane_ready,
    output issue_t [`OOO_NUM_LANES-1:0]         issue,
    input  retire_t [`OOO_RETIRE_WIDTH-1:0]     retire,
    output logic [`OOO_REG_W-1:0]               rd_addr1,
    output logic [`OOO_REG_W-1:0]               rd_addr2,
    input  logic [`OOO_XLEN-1:0]                rd_data1,
    input  logic [`OOO_XLEN-1:0]                rd_data2
);

    // scoreboard: pending bit and youngest rob tag per register
    logic [`OOO_NREGS-1:0]          pending_q;
    rob_tag_t                       sb_tag_q [`OOO_NREGS];

    logic                           src1_wait;
    logic                           src2_wait;
    logic                           accept;
    logic [`OOO_NUM_LANES-1:0]      grant;
    logic [`OOO_NUM_LANES-1:0]      issue_vld;
    logic [`OOO_XLEN-1:0]           opa;
    logic [`OOO_XLEN-1:0]           opb;

    assign rd_addr1    = in_instr.src1;
    assign rd_addr2    = in_instr.src2;
    assign lookup_tag1 = sb_tag_q[in_instr.src1];
    assign lookup_tag2 = sb_tag_q[in_instr.src2];

    // a pending source must already be done in the rob
    assign src1_wait = pending_q[in_instr.src1] && !lookup1.done;
    assign src2_wait = !in_instr.use_imm && pending_q[in_instr.src2] && !lookup2.done;

    // lowest ready lane wins
    assign grant = lane_ready & ~(lane_ready - 1'b1);

    assign in_ready    = !flush && !full && (|lane_ready) && !src1_wait && !src2_wait;
    assign accept      = in_valid && in_ready;
    assign alloc_valid = accept;
    assign alloc_dst   = in_instr.dst;

    // forward from the rob when the producer has not retired yet
    assign opa = pending_q[in_instr.src1] ? lookup1.value : rd_data1;
    assign opb = in_instr.use_imm ? {{(`OOO_XLEN-16){1'b0}}, in_instr.imm} :
                 pending_q[in_instr.src2] ? lookup2.value : rd_data2;

    always_comb begin
        for (int i = 0; i < `OOO_NUM_LANES; i++) begin
            issue[i].valid = accept && grant[i];
            issue[i].op    = in_instr.op;
            issue[i].tag   = alloc_tag;
            issue[i].opa   = opa;
            issue[i].opb   = opb;
            issue_vld[i]   = issue[i].valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            pending_q <= '0;
            for (int r = 0; r < `OOO_NREGS; r++) begin
                sb_tag_q[r] <= '0;
            end
        end else begin
            // clear only if the retiring entry is still the youngest writer
            for (int s = 0; s < `OOO_RETIRE_WIDTH; s++) begin
                if (retire[s].valid && sb_tag_q[retire[s].dst] == retire[s].tag) begin
                    pending_q[retire[s].dst] <= 1'b0;
                end
            end
            // a new allocation overrides a retire on the same register
            if (accept && in_instr.dst != '0) begin
                pending_q[in_instr.dst] <= 1'b1;
                sb_tag_q[in_instr.dst]  <= alloc_tag;
            end
        end
    end

    a_single_issue: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(issue_vld))
        else $error("dispatch_unit: more than one lane issued");

endmodule

// ==== verilog/exec_lane.sv ====
`timescale 1ns/10ps
`include "ooo_params.svh"

module exec_lane
    import ooo_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    flush,
    input  issue_t  issue_in,
    output logic    lane_ready,
    output result_t result
);

    localparam int LAT = `OOO_MUL_LATENCY;

    // last stage drives the write-back port
    result_t [LAT-1:0]          stage_q;
    result_t                    issue_res;
    logic [2*`OOO_XLEN-1:0]     product;
    logic                       is_mul;

    assign is_mul  = (issue_in.op == OP_MUL);
    assign product = issue_in.opa * issue_in.opb;

    always_comb begin
        issue_res.valid = issue_in.valid;
        issue_res.tag   = issue_in.tag;
        case (issue_in.op)
            OP_ADD:  issue_res.value = issue_in.opa + issue_in.opb;
            OP_SUB:  issue_res.value = issue_in.opa - issue_in.opb;
            OP_AND:  issue_res.value = issue_in.opa & issue_in.opb;
            OP_XOR:  issue_res.value = issue_in.opa ^ issue_in.opb;
            OP_MUL:  issue_res.value = product[`OOO_XLEN-1:0];
            default: issue_res.value = '0;
        endcase
    end

    // a multiply about to reach the last stage blocks a simple op
    assign lane_ready = !stage_q[LAT-2].valid;
    assign result     = stage_q[LAT-1];

    always_ff @(posedge clk) begin
        stage_q[0]       <= issue_res;
        stage_q[0].valid <= issue_in.valid && is_mul;
        for (int i = 1; i < LAT; i++) begin
            stage_q[i] <= stage_q[i-1];
        end
        // simple ops skip straight to the output stage
        if (issue_in.valid && !is_mul) begin
            stage_q[LAT-1] <= issue_res;
        end
        if (!rst_n || flush) begin
            for (int i = 0; i < LAT; i++) begin
                stage_q[i].valid <= 1'b0;
            end
        end
    end

    a_issue_ready: assert property (@(posedge clk) disable iff (!rst_n)
        issue_in.valid |-> lane_ready)
        else $error("exec_lane: issue while lane not ready");

endmodule

// ==== verilog/ooo_core_top.sv ====
`timescale 1ns/10ps
`include "ooo_params.svh"

module ooo_core_top
    import ooo_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                flush,
    input  logic                                in_valid,
    input  instr_t                              in_instr,
    output logic                                in_ready,
    output retire_t [`OOO_RETIRE_WIDTH-1:0]     retire
);

    logic                               full;
    rob_tag_t                           alloc_tag;
    logic                               alloc_valid;
    logic [`OOO_REG_W-1:0]              alloc_dst;
    rob_tag_t                           lookup_tag1;
    rob_tag_t                           lookup_tag2;
    operand_t                           lookup1;
    operand_t                           lookup2;
    logic [`OOO_NUM_LANES-1:0]          lane_ready;
    issue_t [`OOO_NUM_LANES-1:0]        issue;
    result_t [`OOO_NUM_LANES-1:0]       result;
    logic [`OOO_REG_W-1:0]              rd_addr1;
    logic [`OOO_REG_W-1:0]              rd_addr2;
    logic [`OOO_XLEN-1:0]               rd_data1;
    logic [`OOO_XLEN-1:0]               rd_data2;

    dispatch_unit dispatch_unit_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_instr    (in_instr),
        .in_ready    (in_ready),
        .full        (full),
        .alloc_tag   (alloc_tag),
        .alloc_valid (alloc_valid),
        .alloc_dst   (alloc_dst),
        .lookup_tag1 (lookup_tag1),
        .lookup_tag2 (lookup_tag2),
        .lookup1     (lookup1),
        .lookup2     (lookup2),
        .lane_ready  (lane_ready),
        .issue       (issue),
        .retire      (retire),
        .rd_addr1    (rd_addr1),
        .rd_addr2    (rd_addr2),
        .rd_data1    (rd_data1),
        .rd_data2    (rd_data2)
    );

    for (genvar i = 0; i < `OOO_NUM_LANES; i++) begin : g_lane
        exec_lane exec_lane_inst (
            .clk        (clk),
            .rst_n      (rst_n),
            .flush      (flush),
            .issue_in   (issue[i]),
            .lane_ready (lane_ready[i]),
            .result     (result[i])
        );
    end

    rob rob_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .alloc_valid (alloc_valid),
        .alloc_dst   (alloc_dst),
        .alloc_tag   (alloc_tag),
        .full        (full),
        .lookup_tag1 (lookup_tag1),
        .lookup_tag2 (lookup_tag2),
        .lookup1     (lookup1),
        .lookup2     (lookup2),
        .result      (result),
        .retire      (retire)
    );

    arch_regfile arch_regfile_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .retire   (retire),
        .rd_addr1 (rd_addr1),
        .rd_addr2 (rd_addr2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2)
    );

endmodule

// ==== verilog/ooo_pkg.sv ====
`include "ooo_params.svh"

package ooo_pkg;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_MUL = 3'd4
    } alu_op_e;

    typedef enum logic [1:0] {
        ENTRY_FREE = 2'd0,
        ENTRY_WAIT = 2'd1,
        ENTRY_DONE = 2'd2
    } entry_state_e;

    typedef logic [`OOO_ROB_ADDR_W-1:0] rob_tag_t;

    // imm is zero-extended and replaces src2 when use_imm is set
    typedef struct packed {
        alu_op_e                op;
        logic [`OOO_REG_W-1:0]  dst;
        logic [`OOO_REG_W-1:0]  src1;
        logic [`OOO_REG_W-1:0]  src2;
        logic [15:0]            imm;
        logic                   use_imm;
    } instr_t;

    typedef struct packed {
        logic                   valid;
        alu_op_e                op;
        rob_tag_t               tag;
        logic [`OOO_XLEN-1:0]   opa;
        logic [`OOO_XLEN-1:0]   opb;
    } issue_t;

    typedef struct packed {
        logic                   valid;
        rob_tag_t               tag;
        logic [`OOO_XLEN-1:0]   value;
    } result_t;

    typedef struct packed {
        logic                   done;
        logic [`OOO_XLEN-1:0]   value;
    } operand_t;

    typedef struct packed {
        entry_state_e           state;
        logic [`OOO_REG_W-1:0]  dst;
        logic [`OOO_XLEN-1:0]   value;
    } rob_entry_t;

    typedef struct packed {
        logic                   valid;
        logic [`OOO_REG_W-1:0]  dst;
        logic [`OOO_XLEN-1:0]   value;
        rob_tag_t               tag;
    } retire_t;

endpackage

// ==== verilog/rob.sv ====
`timescale 1ns/10ps
`include "ooo_params.svh"

module rob
    import ooo_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                flush,
    input  logic                                alloc_valid,
    input  logic [`OOO_REG_W-1:0]               alloc_dst,
    output rob_tag_t                            alloc_tag,
    output logic                                full,
    input  rob_tag_t                            lookup_tag1,
    input  rob_tag_t                            lookup_tag2,
    output operand_t                            lookup1,
    output operand_t                            lookup2,
    input  result_t [`OOO_NUM_LANES-1:0]        result,
    output retire_t [`OOO_RETIRE_WIDTH-1:0]     retire
);

    localparam int DEPTH = `OOO_ROB_DEPTH;
    localparam int AW    = `OOO_ROB_ADDR_W;

    rob_entry_t     entries_q [DEPTH];

    // msb of each pointer is the wrap bit
    logic [AW:0]    head_q;
    logic [AW:0]    tail_q;
    logic [AW:0]    head_next;
    logic [AW:0]    rd_ptr;
    logic           stop;

    assign full = (head_q[AW] != tail_q[AW]) && (head_q[AW-1:0] == tail_q[AW-1:0]);
    assign alloc_tag = tail_q[AW-1:0];

    // operand lookup for dispatch, straight from the registered table
    assign lookup1.done  = (entries_q[lookup_tag1].state == ENTRY_DONE);
    assign lookup1.value = entries_q[lookup_tag1].value;
    assign lookup2.done  = (entries_q[lookup_tag2].state == ENTRY_DONE);
    assign lookup2.value = entries_q[lookup_tag2].value;

    // in-order retire, stop at the first entry not done or at the tail
    always_comb begin
        rd_ptr = head_q;
        stop   = 1'b0;
        for (int i = 0; i < `OOO_RETIRE_WIDTH; i++) begin
            retire[i] = '0;
            if (!stop && rd_ptr != tail_q &&
                entries_q[rd_ptr[AW-1:0]].state == ENTRY_DONE) begin
                retire[i].valid = 1'b1;
                retire[i].dst   = entries_q[rd_ptr[AW-1:0]].dst;
                retire[i].value = entries_q[rd_ptr[AW-1:0]].value;
                retire[i].tag   = rd_ptr[AW-1:0];
                rd_ptr          = rd_ptr + 1'b1;
            end else begin
                stop = 1'b1;
            end
        end
        head_next = rd_ptr;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head_q <= '0;
            tail_q <= '0;
            for (int j = 0; j < DEPTH; j++) begin
                entries_q[j].state <= ENTRY_FREE;
            end
        end else begin
            // write-back by tag
            for (int l = 0; l < `OOO_NUM_LANES; l++) begin
                if (result[l].valid) begin
                    entries_q[result[l].tag].state <= ENTRY_DONE;
                    entries_q[result[l].tag].value <= result[l].value;
                end
            end

            // free retired entries
            for (int s = 0; s < `OOO_RETIRE_WIDTH; s++) begin
                if (retire[s].valid) begin
                    entries_q[retire[s].tag].state <= ENTRY_FREE;
                end
            end
            head_q <= head_next;

            // tail entry is free whenever the buffer is not full
            if (alloc_valid) begin
                entries_q[tail_q[AW-1:0]].state <= ENTRY_WAIT;
                entries_q[tail_q[AW-1:0]].dst   <= alloc_dst;
                tail_q <= tail_q + 1'b1;
            end
        end
    end

    a_no_alloc_full: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_valid |-> !full)
        else $error("rob: allocation while full");

    for (genvar g = 0; g < `OOO_NUM_LANES; g++) begin : g_wb_check
        a_wb_waiting: assert property (@(posedge clk) disable iff (!rst_n || flush)
            result[g].valid |-> entries_q[result[g].tag].state == ENTRY_WAIT)
            else $error("rob: write-back to entry %0d not waiting", result[g].tag);
    end

endmodule
